// File: coh_tile_defs.svh
`ifndef COH_TILE_DEFS_SVH
`define COH_TILE_DEFS_SVH

// Cache engines sharing the directory
`define COH_NUM_LCE 2

// Directory and backing store depth
`define COH_NUM_LINES 16

// Line address width, enough for every line
`define COH_ADDR_W 4

`define COH_DATA_W 32

// Trace opcode, load or store
`define COH_OP_W 1

`endif

// File: coh_tile_pkg.sv
`include "coh_tile_defs.svh"

package coh_tile_pkg;

   typedef logic [`COH_ADDR_W-1:0]          line_addr_t;
   typedef logic [`COH_DATA_W-1:0]          data_word_t;
   typedef logic [$clog2(`COH_NUM_LCE)-1:0] lce_id_t;

   // One bit per LCE
   typedef logic [`COH_NUM_LCE-1:0]         sharer_mask_t;

   typedef enum logic [`COH_OP_W-1:0] {
      e_op_load  = 1'b0,
      e_op_store = 1'b1
   } tr_op_e;

   typedef enum logic [1:0] {
      e_lce_idle,
      e_lce_send,
      e_lce_wait_resp,
      e_lce_reply
   } lce_state_e;

   typedef enum logic [1:0] {
      e_cce_ready,
      e_cce_lookup,
      e_cce_respond
   } cce_state_e;

endpackage

// File: mock_lce.sv
`timescale 1ns/10ps

module mock_lce (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       tr_pkt_v_i,
   input  coh_tile_pkg::tr_op_e       tr_op_i,
   input  coh_tile_pkg::line_addr_t   tr_addr_i,
   input  coh_tile_pkg::data_word_t   tr_data_i,
   output logic                       tr_pkt_yumi_o,
   input  logic                       tr_pkt_ready_i,
   output logic                       tr_pkt_v_o,
   output coh_tile_pkg::tr_op_e       tr_op_o,
   output coh_tile_pkg::line_addr_t   tr_addr_o,
   output coh_tile_pkg::data_word_t   tr_data_o,
   output coh_tile_pkg::sharer_mask_t tr_inv_o,
   output logic                       lce_req_v_o,
   output coh_tile_pkg::tr_op_e       lce_req_op_o,
   output coh_tile_pkg::line_addr_t   lce_req_addr_o,
   output coh_tile_pkg::data_word_t   lce_req_data_o,
   input  logic                       lce_req_ready_i,
   input  logic                       lce_resp_v_i,
   input  coh_tile_pkg::data_word_t   lce_resp_data_i,
   input  coh_tile_pkg::sharer_mask_t lce_resp_inv_i
);
   import coh_tile_pkg::*;

   lce_state_e   state_r;
   lce_state_e   state_n;
   tr_op_e       op_r;
   line_addr_t   addr_r;
   data_word_t   data_r;
   data_word_t   resp_data_r;
   sharer_mask_t resp_inv_r;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         state_r <= e_lce_idle;
      else
         state_r <= state_n;
   end

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         e_lce_idle:
            if (tr_pkt_v_i)
               state_n = e_lce_send;
         e_lce_send:
            if (lce_req_ready_i)
               state_n = e_lce_wait_resp;
         // Always ready for the reply here
         e_lce_wait_resp:
            if (lce_resp_v_i)
               state_n = e_lce_reply;
         e_lce_reply:
            if (tr_pkt_ready_i)
               state_n = e_lce_idle;
         default:
            state_n = e_lce_idle;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (tr_pkt_yumi_o)
      begin
         op_r   <= tr_op_i;
         addr_r <= tr_addr_i;
         data_r <= tr_data_i;
      end
      if (state_r == e_lce_wait_resp && lce_resp_v_i)
      begin
         resp_data_r <= lce_resp_data_i;
         resp_inv_r  <= lce_resp_inv_i;
      end
   end

   // Take a new trace only when idle
   assign tr_pkt_yumi_o  = (state_r == e_lce_idle) && tr_pkt_v_i;

   assign lce_req_v_o    = (state_r == e_lce_send);
   assign lce_req_op_o   = op_r;
   assign lce_req_addr_o = addr_r;
   assign lce_req_data_o = data_r;

   // Held until the outside takes it
   assign tr_pkt_v_o     = (state_r == e_lce_reply);
   assign tr_op_o        = op_r;
   assign tr_addr_o      = addr_r;
   assign tr_data_o      = resp_data_r;
   assign tr_inv_o       = resp_inv_r;

endmodule

// File: lce_req_arbiter.sv
`timescale 1ns/10ps
`include "coh_tile_defs.svh"

module lce_req_arbiter (
   input  logic                                          clk_i,
   input  logic                                          arst_n_i,
   input  logic                       [`COH_NUM_LCE-1:0] lce_req_v_i,
   input  coh_tile_pkg::tr_op_e       [`COH_NUM_LCE-1:0] lce_req_op_i,
   input  coh_tile_pkg::line_addr_t   [`COH_NUM_LCE-1:0] lce_req_addr_i,
   input  coh_tile_pkg::data_word_t   [`COH_NUM_LCE-1:0] lce_req_data_i,
   output logic                       [`COH_NUM_LCE-1:0] lce_req_ready_o,
   output logic                       [`COH_NUM_LCE-1:0] lce_resp_v_o,
   output coh_tile_pkg::data_word_t   [`COH_NUM_LCE-1:0] lce_resp_data_o,
   output coh_tile_pkg::sharer_mask_t [`COH_NUM_LCE-1:0] lce_resp_inv_o,
   output logic                                          cce_req_v_o,
   output coh_tile_pkg::lce_id_t                         cce_req_src_o,
   output coh_tile_pkg::tr_op_e                          cce_req_op_o,
   output coh_tile_pkg::line_addr_t                      cce_req_addr_o,
   output coh_tile_pkg::data_word_t                      cce_req_data_o,
   input  logic                                          cce_req_ready_i,
   input  logic                                          cce_resp_v_i,
   input  coh_tile_pkg::lce_id_t                         cce_resp_dst_i,
   input  coh_tile_pkg::data_word_t                      cce_resp_data_i,
   input  coh_tile_pkg::sharer_mask_t                    cce_resp_inv_i
);
   import coh_tile_pkg::*;

   lce_id_t prio_r;
   lce_id_t gnt_id;
   logic    req_accept;

   // Favoured LCE wins a tie, else whichever one is valid
   assign gnt_id     = lce_req_v_i[prio_r] ? prio_r : ~prio_r;
   assign req_accept = cce_req_v_o && cce_req_ready_i;

   assign cce_req_v_o    = |lce_req_v_i;
   assign cce_req_src_o  = gnt_id;
   assign cce_req_op_o   = lce_req_op_i[gnt_id];
   assign cce_req_addr_o = lce_req_addr_i[gnt_id];
   assign cce_req_data_o = lce_req_data_i[gnt_id];

   always_comb
   begin
      for (int i = 0; i < `COH_NUM_LCE; i++)
      begin
         lce_req_ready_o[i] = cce_req_ready_i && (gnt_id == lce_id_t'(i));
         lce_resp_v_o[i]    = cce_resp_v_i && (cce_resp_dst_i == lce_id_t'(i));
         lce_resp_data_o[i] = cce_resp_data_i;
         lce_resp_inv_o[i]  = cce_resp_inv_i;
      end
   end

   // Loser of the last accepted transfer goes first next time
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         prio_r <= '0;
      else if (req_accept)
         prio_r <= ~gnt_id;
   end

endmodule

// File: cce_directory.sv
`timescale 1ns/10ps
`include "coh_tile_defs.svh"

module cce_directory (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       cce_req_v_i,
   input  coh_tile_pkg::lce_id_t      cce_req_src_i,
   input  coh_tile_pkg::tr_op_e       cce_req_op_i,
   input  coh_tile_pkg::line_addr_t   cce_req_addr_i,
   input  coh_tile_pkg::data_word_t   cce_req_data_i,
   output logic                       cce_req_ready_o,
   output logic                       cce_resp_v_o,
   output coh_tile_pkg::lce_id_t      cce_resp_dst_o,
   output coh_tile_pkg::data_word_t   cce_resp_data_o,
   output coh_tile_pkg::sharer_mask_t cce_resp_inv_o
);
   import coh_tile_pkg::*;

   cce_state_e   state_r;
   logic         req_accept;
   lce_id_t      req_src_r;
   tr_op_e       req_op_r;
   line_addr_t   req_addr_r;
   data_word_t   req_data_r;
   sharer_mask_t src_mask;
   data_word_t   resp_data_r;
   sharer_mask_t resp_inv_r;

   data_word_t   store_r   [`COH_NUM_LINES];
   sharer_mask_t sharers_r [`COH_NUM_LINES];

   assign req_accept = cce_req_v_i && cce_req_ready_o;
   assign src_mask   = sharer_mask_t'(1) << req_src_r;

   // Accept, lookup, respond, then ready again
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         state_r <= e_cce_ready;
      else
      begin
         case (state_r)
            e_cce_ready:
               if (req_accept)
                  state_r <= e_cce_lookup;
            e_cce_lookup:
               state_r <= e_cce_respond;
            default:
               state_r <= e_cce_ready;
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int i = 0; i < `COH_NUM_LINES; i++)
         begin
            store_r[i]   <= '0;
            sharers_r[i] <= '0;
         end
      end
      else if (state_r == e_cce_lookup)
      begin
         // Writer becomes the sole sharer
         if (req_op_r == e_op_store)
         begin
            store_r[req_addr_r]   <= req_data_r;
            sharers_r[req_addr_r] <= src_mask;
         end
         else
            sharers_r[req_addr_r] <= sharers_r[req_addr_r] | src_mask;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (req_accept)
      begin
         req_src_r  <= cce_req_src_i;
         req_op_r   <= cce_req_op_i;
         req_addr_r <= cce_req_addr_i;
         req_data_r <= cce_req_data_i;
      end
      if (state_r == e_cce_lookup)
      begin
         if (req_op_r == e_op_store)
         begin
            resp_data_r <= req_data_r;
            // Other holders must drop the line
            resp_inv_r  <= sharers_r[req_addr_r] & ~src_mask;
         end
         else
         begin
            resp_data_r <= store_r[req_addr_r];
            resp_inv_r  <= '0;
         end
      end
   end

   assign cce_req_ready_o = (state_r == e_cce_ready);
   assign cce_resp_v_o    = (state_r == e_cce_respond);
   assign cce_resp_dst_o  = req_src_r;
   assign cce_resp_data_o = resp_data_r;
   assign cce_resp_inv_o  = resp_inv_r;

endmodule

// File: coh_tile.sv
`timescale 1ns/10ps
`include "coh_tile_defs.svh"

module coh_tile (
   input  logic                                          clk_i,
   input  logic                                          arst_n_i,
   input  logic                       [`COH_NUM_LCE-1:0] tr_pkt_v_i,
   input  coh_tile_pkg::tr_op_e       [`COH_NUM_LCE-1:0] tr_op_i,
   input  coh_tile_pkg::line_addr_t   [`COH_NUM_LCE-1:0] tr_addr_i,
   input  coh_tile_pkg::data_word_t   [`COH_NUM_LCE-1:0] tr_data_i,
   output logic                       [`COH_NUM_LCE-1:0] tr_pkt_yumi_o,
   input  logic                       [`COH_NUM_LCE-1:0] tr_pkt_ready_i,
   output logic                       [`COH_NUM_LCE-1:0] tr_pkt_v_o,
   output coh_tile_pkg::tr_op_e       [`COH_NUM_LCE-1:0] tr_op_o,
   output coh_tile_pkg::line_addr_t   [`COH_NUM_LCE-1:0] tr_addr_o,
   output coh_tile_pkg::data_word_t   [`COH_NUM_LCE-1:0] tr_data_o,
   output coh_tile_pkg::sharer_mask_t [`COH_NUM_LCE-1:0] tr_inv_o
);
   import coh_tile_pkg::*;

   // LCE side of the arbiter
   logic         [`COH_NUM_LCE-1:0] lce_req_v;
   tr_op_e       [`COH_NUM_LCE-1:0] lce_req_op;
   line_addr_t   [`COH_NUM_LCE-1:0] lce_req_addr;
   data_word_t   [`COH_NUM_LCE-1:0] lce_req_data;
   logic         [`COH_NUM_LCE-1:0] lce_req_ready;
   logic         [`COH_NUM_LCE-1:0] lce_resp_v;
   data_word_t   [`COH_NUM_LCE-1:0] lce_resp_data;
   sharer_mask_t [`COH_NUM_LCE-1:0] lce_resp_inv;

   // CCE side
   logic         cce_req_v;
   lce_id_t      cce_req_src;
   tr_op_e       cce_req_op;
   line_addr_t   cce_req_addr;
   data_word_t   cce_req_data;
   logic         cce_req_ready;
   logic         cce_resp_v;
   lce_id_t      cce_resp_dst;
   data_word_t   cce_resp_data;
   sharer_mask_t cce_resp_inv;

   mock_lce u_lce0 (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .tr_pkt_v_i     (tr_pkt_v_i[0]),
      .tr_op_i        (tr_op_i[0]),
      .tr_addr_i      (tr_addr_i[0]),
      .tr_data_i      (tr_data_i[0]),
      .tr_pkt_yumi_o  (tr_pkt_yumi_o[0]),
      .tr_pkt_ready_i (tr_pkt_ready_i[0]),
      .tr_pkt_v_o     (tr_pkt_v_o[0]),
      .tr_op_o        (tr_op_o[0]),
      .tr_addr_o      (tr_addr_o[0]),
      .tr_data_o      (tr_data_o[0]),
      .tr_inv_o       (tr_inv_o[0]),
      .lce_req_v_o    (lce_req_v[0]),
      .lce_req_op_o   (lce_req_op[0]),
      .lce_req_addr_o (lce_req_addr[0]),
      .lce_req_data_o (lce_req_data[0]),
      .lce_req_ready_i(lce_req_ready[0]),
      .lce_resp_v_i   (lce_resp_v[0]),
      .lce_resp_data_i(lce_resp_data[0]),
      .lce_resp_inv_i (lce_resp_inv[0])
   );

   mock_lce u_lce1 (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .tr_pkt_v_i     (tr_pkt_v_i[1]),
      .tr_op_i        (tr_op_i[1]),
      .tr_addr_i      (tr_addr_i[1]),
      .tr_data_i      (tr_data_i[1]),
      .tr_pkt_yumi_o  (tr_pkt_yumi_o[1]),
      .tr_pkt_ready_i (tr_pkt_ready_i[1]),
      .tr_pkt_v_o     (tr_pkt_v_o[1]),
      .tr_op_o        (tr_op_o[1]),
      .tr_addr_o      (tr_addr_o[1]),
      .tr_data_o      (tr_data_o[1]),
      .tr_inv_o       (tr_inv_o[1]),
      .lce_req_v_o    (lce_req_v[1]),
      .lce_req_op_o   (lce_req_op[1]),
      .lce_req_addr_o (lce_req_addr[1]),
      .lce_req_data_o (lce_req_data[1]),
      .lce_req_ready_i(lce_req_ready[1]),
      .lce_resp_v_i   (lce_resp_v[1]),
      .lce_resp_data_i(lce_resp_data[1]),
      .lce_resp_inv_i (lce_resp_inv[1])
   );

   lce_req_arbiter u_arb (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .lce_req_v_i    (lce_req_v),
      .lce_req_op_i   (lce_req_op),
      .lce_req_addr_i (lce_req_addr),
      .lce_req_data_i (lce_req_data),
      .lce_req_ready_o(lce_req_ready),
      .lce_resp_v_o   (lce_resp_v),
      .lce_resp_data_o(lce_resp_data),
      .lce_resp_inv_o (lce_resp_inv),
      .cce_req_v_o    (cce_req_v),
      .cce_req_src_o  (cce_req_src),
      .cce_req_op_o   (cce_req_op),
      .cce_req_addr_o (cce_req_addr),
      .cce_req_data_o (cce_req_data),
      .cce_req_ready_i(cce_req_ready),
      .cce_resp_v_i   (cce_resp_v),
      .cce_resp_dst_i (cce_resp_dst),
      .cce_resp_data_i(cce_resp_data),
      .cce_resp_inv_i (cce_resp_inv)
   );

   cce_directory u_cce (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .cce_req_v_i    (cce_req_v),
      .cce_req_src_i  (cce_req_src),
      .cce_req_op_i   (cce_req_op),
      .cce_req_addr_i (cce_req_addr),
      .cce_req_data_i (cce_req_data),
      .cce_req_ready_o(cce_req_ready),
      .cce_resp_v_o   (cce_resp_v),
      .cce_resp_dst_o (cce_resp_dst),
      .cce_resp_data_o(cce_resp_data),
      .cce_resp_inv_o (cce_resp_inv)
   );

endmodule

// File: coh_tile_assert.sv
`timescale 1ns/10ps
`include "coh_tile_defs.svh"

module coh_tile_assert (
   input  logic                                          clk_i,
   input  logic                                          arst_n_i,
   input  logic                       [`COH_NUM_LCE-1:0] out_v_i,
   input  logic                       [`COH_NUM_LCE-1:0] out_ready_i,
   input  coh_tile_pkg::tr_op_e       [`COH_NUM_LCE-1:0] out_op_i,
   input  coh_tile_pkg::line_addr_t   [`COH_NUM_LCE-1:0] out_addr_i,
   input  coh_tile_pkg::data_word_t   [`COH_NUM_LCE-1:0] out_data_i,
   input  coh_tile_pkg::sharer_mask_t [`COH_NUM_LCE-1:0] out_inv_i,
   input  logic                       [`COH_NUM_LCE-1:0] lce_req_v_i,
   input  logic                       [`COH_NUM_LCE-1:0] lce_req_ready_i,
   input  logic                                          cce_req_v_i,
   input  logic                                          cce_req_ready_i,
   input  logic                                          cce_resp_v_i
);

   int   fail_cnt = 0;
   logic last_win_r;

   // Winner of the last accepted transfer, LCE 1 out of reset so LCE 0 goes first
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         last_win_r <= 1'b1;
      else if (lce_req_v_i[0] && lce_req_ready_i[0])
         last_win_r <= 1'b0;
      else if (lce_req_v_i[1] && lce_req_ready_i[1])
         last_win_r <= 1'b1;
   end

   for (genvar g = 0; g < `COH_NUM_LCE; g++)
   begin : g_lce
      // Reply stays put until the outside takes it
      assert property (@(posedge clk_i) disable iff (!arst_n_i)
         out_v_i[g] && !out_ready_i[g] |=> out_v_i[g] && $stable(out_op_i[g])
            && $stable(out_addr_i[g]) && $stable(out_data_i[g]) && $stable(out_inv_i[g]))
      else
      begin
         fail_cnt++;
         $error("LCE %0d trace output changed while ready was low", g);
      end
   end

   // Contended grant goes only to the loser of the last transfer
   assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cce_req_ready_i && (&lce_req_v_i)
         |-> lce_req_ready_i[~last_win_r] && !lce_req_ready_i[last_win_r])
   else
   begin
      fail_cnt++;
      $error("Arbiter gave ready to the wrong LCE or to both LCEs");
   end

   // Lookup then respond
   assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cce_resp_v_i |-> $past(cce_req_v_i && cce_req_ready_i, 2))
   else
   begin
      fail_cnt++;
      $error("CCE response without an accepted request");
   end

endmodule

bind coh_tile coh_tile_assert u_assert (
   .clk_i          (clk_i),
   .arst_n_i       (arst_n_i),
   .out_v_i        (tr_pkt_v_o),
   .out_ready_i    (tr_pkt_ready_i),
   .out_op_i       (tr_op_o),
   .out_addr_i     (tr_addr_o),
   .out_data_i     (tr_data_o),
   .out_inv_i      (tr_inv_o),
   .lce_req_v_i    (lce_req_v),
   .lce_req_ready_i(lce_req_ready),
   .cce_req_v_i    (cce_req_v),
   .cce_req_ready_i(cce_req_ready),
   .cce_resp_v_i   (cce_resp_v)
);

// File: coh_tile_checker.sv
`timescale 1ns/10ps
`include "coh_tile_defs.svh"

module coh_tile_checker (
   input  logic                                          clk_i,
   input  logic                                          arst_n_i,
   input  logic                       [`COH_NUM_LCE-1:0] in_yumi_i,
   input  coh_tile_pkg::tr_op_e       [`COH_NUM_LCE-1:0] in_op_i,
   input  coh_tile_pkg::line_addr_t   [`COH_NUM_LCE-1:0] in_addr_i,
   input  coh_tile_pkg::data_word_t   [`COH_NUM_LCE-1:0] exp_data_i,
   input  coh_tile_pkg::sharer_mask_t [`COH_NUM_LCE-1:0] exp_inv_i,
   input  logic                       [`COH_NUM_LCE-1:0] out_v_i,
   input  logic                       [`COH_NUM_LCE-1:0] out_ready_i,
   input  coh_tile_pkg::tr_op_e       [`COH_NUM_LCE-1:0] out_op_i,
   input  coh_tile_pkg::line_addr_t   [`COH_NUM_LCE-1:0] out_addr_i,
   input  coh_tile_pkg::data_word_t   [`COH_NUM_LCE-1:0] out_data_i,
   input  coh_tile_pkg::sharer_mask_t [`COH_NUM_LCE-1:0] out_inv_i,
   input  int                                            test_num_i,
   input  logic                                          test_end_i,
   output int                                            err_cnt_o,
   output int                                            trace_cnt_o,
   output int                                            pend_cnt_o
);
   import coh_tile_pkg::*;

   localparam int DEPTH = 64;

   // Expected traces per LCE, in the order the LCE took them
   tr_op_e       q_op   [`COH_NUM_LCE][DEPTH];
   line_addr_t   q_addr [`COH_NUM_LCE][DEPTH];
   data_word_t   q_data [`COH_NUM_LCE][DEPTH];
   sharer_mask_t q_inv  [`COH_NUM_LCE][DEPTH];
   int           wr_ptr [`COH_NUM_LCE];
   int           rd_ptr [`COH_NUM_LCE];

   logic         held_r    [`COH_NUM_LCE];
   tr_op_e       held_op   [`COH_NUM_LCE];
   line_addr_t   held_addr [`COH_NUM_LCE];
   data_word_t   held_data [`COH_NUM_LCE];
   sharer_mask_t held_inv  [`COH_NUM_LCE];
   int           test_traces;
   int           test_errs;

   initial
   begin
      err_cnt_o   = 0;
      trace_cnt_o = 0;
      pend_cnt_o  = 0;
      test_traces = 0;
      test_errs   = 0;
   end

   task automatic report_mismatch(input int lce, input string name,
                                  input logic [31:0] got, input logic [31:0] exp);
      $display("[ERROR] test %0d LCE %0d %s: got 0x%0h, expected 0x%0h",
               test_num_i, lce, name, got, exp);
      err_cnt_o++;
      test_errs++;
   endtask

   task automatic report_problem(input int lce, input string what);
      $display("Test %0d LCE %0d: %s", test_num_i, lce, what);
      err_cnt_o++;
      test_errs++;
   endtask

   task automatic check_trace(input int i);
      int slot;
      if (wr_ptr[i] == rd_ptr[i])
         report_problem(i, "returned a trace that was never issued");
      else
      begin
         slot = rd_ptr[i] % DEPTH;
         rd_ptr[i]++;
         trace_cnt_o++;
         test_traces++;
         if (out_op_i[i] !== q_op[i][slot])
            report_mismatch(i, "tr_op_o", out_op_i[i], q_op[i][slot]);
         if (out_addr_i[i] !== q_addr[i][slot])
            report_mismatch(i, "tr_addr_o", out_addr_i[i], q_addr[i][slot]);
         if (out_data_i[i] !== q_data[i][slot])
            report_mismatch(i, "tr_data_o", out_data_i[i], q_data[i][slot]);
         if (out_inv_i[i] !== q_inv[i][slot])
            report_mismatch(i, "tr_inv_o", out_inv_i[i], q_inv[i][slot]);
      end
   endtask

   task automatic check_hold(input int i);
      if (out_v_i[i] && !out_ready_i[i] && in_yumi_i[i])
         report_problem(i, "took a new trace while its reply was held");
      if (held_r[i])
      begin
         if (!out_v_i[i])
            report_problem(i, "dropped its trace output before it was taken");
         else
         begin
            if (out_data_i[i] !== held_data[i])
               report_mismatch(i, "tr_data_o while held", out_data_i[i], held_data[i]);
            if (out_inv_i[i] !== held_inv[i])
               report_mismatch(i, "tr_inv_o while held", out_inv_i[i], held_inv[i]);
            if (out_op_i[i] !== held_op[i] || out_addr_i[i] !== held_addr[i])
               report_mismatch(i, "tr_addr_o while held", out_addr_i[i], held_addr[i]);
         end
      end
   endtask

   always @(posedge clk_i)
   begin
      if (!arst_n_i)
      begin
         if (out_v_i != '0)
            report_problem(0, "trace output valid during reset");
         for (int i = 0; i < `COH_NUM_LCE; i++)
         begin
            wr_ptr[i] = 0;
            rd_ptr[i] = 0;
            held_r[i] = 1'b0;
         end
      end
      else
      begin
         for (int i = 0; i < `COH_NUM_LCE; i++)
         begin
            check_hold(i);
            if (in_yumi_i[i])
            begin
               q_op[i][wr_ptr[i] % DEPTH]   = in_op_i[i];
               q_addr[i][wr_ptr[i] % DEPTH] = in_addr_i[i];
               q_data[i][wr_ptr[i] % DEPTH] = exp_data_i[i];
               q_inv[i][wr_ptr[i] % DEPTH]  = exp_inv_i[i];
               wr_ptr[i]++;
            end
            if (out_v_i[i] && out_ready_i[i])
               check_trace(i);
            held_r[i]    = out_v_i[i] && !out_ready_i[i];
            held_op[i]   = out_op_i[i];
            held_addr[i] = out_addr_i[i];
            held_data[i] = out_data_i[i];
            held_inv[i]  = out_inv_i[i];
         end
         if (test_end_i)
         begin
            $display("Test %0d finished: %0d traces, %0d errors",
                     test_num_i, test_traces, test_errs);
            test_traces = 0;
            test_errs   = 0;
         end
      end
      pend_cnt_o = 0;
      for (int i = 0; i < `COH_NUM_LCE; i++)
         pend_cnt_o += wr_ptr[i] - rd_ptr[i];
   end

endmodule

// File: coh_tile_tb.sv
`timescale 1ns/10ps
`include "coh_tile_defs.svh"

module coh_tile_tb;
   import coh_tile_pkg::*;

   localparam int MAX_LINES       = 64;
   localparam int RESET_CYCLES    = 8;
   localparam int CYCLES_PER_LINE = 40;
   // From this test on, both LCE streams run side by side
   localparam int FIRST_PARALLEL_TEST = 4;

   logic                            clk;
   logic                            arst_n;
   logic         [`COH_NUM_LCE-1:0] in_v;
   tr_op_e       [`COH_NUM_LCE-1:0] in_op;
   line_addr_t   [`COH_NUM_LCE-1:0] in_addr;
   data_word_t   [`COH_NUM_LCE-1:0] in_data;
   logic         [`COH_NUM_LCE-1:0] in_yumi;
   logic         [`COH_NUM_LCE-1:0] out_ready;
   logic         [`COH_NUM_LCE-1:0] out_v;
   tr_op_e       [`COH_NUM_LCE-1:0] out_op;
   line_addr_t   [`COH_NUM_LCE-1:0] out_addr;
   data_word_t   [`COH_NUM_LCE-1:0] out_data;
   sharer_mask_t [`COH_NUM_LCE-1:0] out_inv;
   data_word_t   [`COH_NUM_LCE-1:0] exp_data;
   sharer_mask_t [`COH_NUM_LCE-1:0] exp_inv;

   int           st_test    [MAX_LINES];
   int           st_lce     [MAX_LINES];
   logic         st_op      [MAX_LINES];
   line_addr_t   st_addr    [MAX_LINES];
   data_word_t   st_data    [MAX_LINES];
   data_word_t   st_exp_data[MAX_LINES];
   sharer_mask_t st_exp_inv [MAX_LINES];
   int           st_hold    [MAX_LINES];
   int           num_lines;

   // Hold time per accepted trace, 0 means ready stays high
   int           hold_fifo  [`COH_NUM_LCE][MAX_LINES];
   int           hold_wr    [`COH_NUM_LCE];
   int           hold_rd    [`COH_NUM_LCE];

   int           cur_test;
   logic         test_end;
   int           tests_run;
   int           cycle_cnt;
   int           cycle_limit;
   logic         limit_set;
   int           err_cnt;
   int           trace_cnt;
   int           pend_cnt;

   coh_tile u_coh_tile (
      .clk_i         (clk),
      .arst_n_i      (arst_n),
      .tr_pkt_v_i    (in_v),
      .tr_op_i       (in_op),
      .tr_addr_i     (in_addr),
      .tr_data_i     (in_data),
      .tr_pkt_yumi_o (in_yumi),
      .tr_pkt_ready_i(out_ready),
      .tr_pkt_v_o    (out_v),
      .tr_op_o       (out_op),
      .tr_addr_o     (out_addr),
      .tr_data_o     (out_data),
      .tr_inv_o      (out_inv)
   );

   coh_tile_checker u_checker (
      .clk_i      (clk),
      .arst_n_i   (arst_n),
      .in_yumi_i  (in_yumi),
      .in_op_i    (in_op),
      .in_addr_i  (in_addr),
      .exp_data_i (exp_data),
      .exp_inv_i  (exp_inv),
      .out_v_i    (out_v),
      .out_ready_i(out_ready),
      .out_op_i   (out_op),
      .out_addr_i (out_addr),
      .out_data_i (out_data),
      .out_inv_i  (out_inv),
      .test_num_i (cur_test),
      .test_end_i (test_end),
      .err_cnt_o  (err_cnt),
      .trace_cnt_o(trace_cnt),
      .pend_cnt_o (pend_cnt)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (limit_set && cycle_cnt >= cycle_limit)
      begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("TB FAILED");
         $finish;
      end
   end

   task automatic load_stim(output logic ok);
      int          fd;
      int          n;
      string       text;
      int          t;
      int          l;
      int          o;
      int          b;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] ed;
      logic [31:0] ei;
      ok        = 1'b0;
      num_lines = 0;
      fd        = $fopen("coh_tile_stim.txt", "r");
      if (fd == 0)
         $display("Could not open the stimulus file coh_tile_stim.txt");
      else
      begin
         while (!$feof(fd))
         begin
            text = "";
            n    = $fgets(text, fd);
            if (n > 0 && text.len() > 0 && text[0] != "#")
            begin
               n = $sscanf(text, "%d %d %d %h %h %h %h %d", t, l, o, a, d, ed, ei, b);
               if (n == 8 && num_lines < MAX_LINES)
               begin
                  st_test[num_lines]     = t;
                  st_lce[num_lines]      = l;
                  st_op[num_lines]       = o[0];
                  st_addr[num_lines]     = a[`COH_ADDR_W-1:0];
                  st_data[num_lines]     = d;
                  st_exp_data[num_lines] = ed;
                  st_exp_inv[num_lines]  = ei[`COH_NUM_LCE-1:0];
                  st_hold[num_lines]     = (b != 0) ? 1 + ($urandom % 5) : 0;
                  num_lines++;
               end
            end
         end
         $fclose(fd);
         ok = (num_lines > 0);
         if (!ok)
            $display("No stimulus lines found in coh_tile_stim.txt");
      end
   endtask

   // Present one trace and wait until the LCE takes it
   task automatic drive_line(input int idx);
      int lce;
      lce = st_lce[idx];
      @(negedge clk);
      in_v[lce]     = 1'b1;
      in_op[lce]    = tr_op_e'(st_op[idx]);
      in_addr[lce]  = st_addr[idx];
      in_data[lce]  = st_data[idx];
      exp_data[lce] = st_exp_data[idx];
      exp_inv[lce]  = st_exp_inv[idx];
      @(posedge clk);
      while (!in_yumi[lce])
         @(posedge clk);
      hold_fifo[lce][hold_wr[lce]] = st_hold[idx];
      hold_wr[lce]++;
      @(negedge clk);
      in_v[lce] = 1'b0;
   endtask

   task automatic run_stream(input int lce, input int first, input int last);
      for (int i = first; i < last; i++)
      begin
         if (st_lce[i] == lce)
            drive_line(i);
      end
   endtask

   task automatic wait_drain();
      @(negedge clk);
      while (pend_cnt != 0)
         @(negedge clk);
   endtask

   task automatic run_test(input int first, input int last);
      @(negedge clk);
      cur_test = st_test[first];
      if (cur_test >= FIRST_PARALLEL_TEST)
      begin
         fork
            run_stream(0, first, last);
            run_stream(1, first, last);
         join
      end
      else
      begin
         for (int i = first; i < last; i++)
         begin
            drive_line(i);
            wait_drain();
         end
      end
      wait_drain();
      test_end = 1'b1;
      @(negedge clk);
      test_end = 1'b0;
      tests_run++;
   endtask

   // Trace-out ready for one LCE, low for the hold time of back-pressure lines
   task automatic ready_ctrl(input int lce);
      int hold;
      forever
      begin
         @(negedge clk);
         if (hold_rd[lce] != hold_wr[lce])
         begin
            hold = hold_fifo[lce][hold_rd[lce]];
            hold_rd[lce]++;
            if (hold > 0)
            begin
               out_ready[lce] = 1'b0;
               @(posedge clk);
               while (!out_v[lce])
                  @(posedge clk);
               repeat (hold - 1) @(posedge clk);
               @(negedge clk);
               out_ready[lce] = 1'b1;
            end
            @(posedge clk);
            while (!(out_v[lce] && out_ready[lce]))
               @(posedge clk);
         end
      end
   endtask

   initial ready_ctrl(0);
   initial ready_ctrl(1);

   initial
   begin
      logic ok;
      int   idx;
      int   first;
      int   asrt_fails;
      void'($urandom(48668));
      clk         = 1'b0;
      arst_n      = 1'b0;
      in_v        = '0;
      in_addr     = '0;
      in_data     = '0;
      out_ready   = '1;
      exp_data    = '0;
      exp_inv     = '0;
      cur_test    = 0;
      test_end    = 1'b0;
      tests_run   = 0;
      cycle_cnt   = 0;
      cycle_limit = 0;
      limit_set   = 1'b0;
      for (int i = 0; i < `COH_NUM_LCE; i++)
      begin
         in_op[i]   = e_op_load;
         hold_wr[i] = 0;
         hold_rd[i] = 0;
      end
      load_stim(ok);
      if (!ok)
         $display("TB FAILED");
      else
      begin
         cycle_limit = CYCLES_PER_LINE * num_lines + RESET_CYCLES;
         limit_set   = 1'b1;
         repeat (RESET_CYCLES) @(posedge clk);
         @(negedge clk);
         arst_n = 1'b1;
         idx    = 0;
         while (idx < num_lines)
         begin
            first = idx;
            while (idx < num_lines && st_test[idx] == st_test[first])
               idx++;
            run_test(first, idx);
         end
         @(negedge clk);
         asrt_fails = u_coh_tile.u_assert.fail_cnt;
         $display("Summary: %0d tests, %0d traces checked, %0d errors, %0d assertion failures",
                  tests_run, trace_cnt, err_cnt, asrt_fails);
         if (err_cnt == 0 && asrt_fails == 0)
            $display("TB PASSED");
         else
            $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: coh_tile_stim.txt
# test lce op(0 load, 1 store) addr data expected_data expected_inv back_pressure
# addr, data, expected_data and expected_inv in hex, the other columns in decimal
1 0 0 3 00000000 00000000 0 0
1 1 0 c 00000000 00000000 0 0
2 0 1 7 a5a50001 a5a50001 0 0
2 0 0 7 00000000 a5a50001 0 0
2 1 1 9 1234abcd 1234abcd 0 0
2 1 0 9 00000000 1234abcd 0 0
3 0 0 5 00000000 00000000 0 0
3 1 1 5 cafe0005 cafe0005 1 0
3 0 0 5 00000000 cafe0005 0 0
3 0 1 5 0bad0005 0bad0005 2 0
4 0 1 0 11110000 11110000 0 0
4 1 1 8 22220008 22220008 0 0
4 0 1 1 11110001 11110001 0 0
4 1 1 a 2222000a 2222000a 0 0
4 0 0 0 00000000 11110000 0 0
4 1 0 8 00000000 22220008 0 0
5 0 1 2 33330002 33330002 0 1
5 1 1 b 4444000b 4444000b 0 0
5 0 0 2 00000000 33330002 0 1
5 1 0 b 00000000 4444000b 0 0
5 1 0 d 00000000 00000000 0 0

// File: coh_tile.f
+incdir+.
coh_tile_pkg.sv
mock_lce.sv
lce_req_arbiter.sv
cce_directory.sv
coh_tile.sv
coh_tile_assert.sv
coh_tile_checker.sv
coh_tile_tb.sv
